// File: src.f
+incdir+hw
hw/spi_pkg.sv
hw/spi_sck_gen.sv
hw/spi_shift_engine.sv
hw/spi_regs.sv
hw/spi_top.sv
dv/spi_slave_model.sv
dv/spi_properties.sv
dv/tb_spi_top.sv

// File: Bender.yml
package:
  name: spi_master

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/spi_pkg.sv
      - hw/spi_sck_gen.sv
      - hw/spi_shift_engine.sv
      - hw/spi_regs.sv
      - hw/spi_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/spi_slave_model.sv
      - dv/spi_properties.sv
      - dv/tb_spi_top.sv

// File: dv/tb_spi_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module tb_spi_top;

	import spi_pkg::*;

	// Wait bounds
	localparam int RD_LIMIT   = 8;
	localparam int POLL_LIMIT = 300;
	localparam int PIN_LIMIT  = 800;

	logic                   clk;
	logic                   rst_n;
	spi_bus_req_t           req;
	logic [`SPI_DATA_W-1:0] rdata;
	logic                   rvalid;
	logic                   sck;
	logic                   mosi;
	logic                   miso;
	logic [3:0]             ss_n;

	// Slave setup for the current test
	logic [1:0]             slave_sel;
	logic                   slave_cpol;
	logic                   slave_cpha;
	logic                   slave_order;
	logic [7:0]             slave_tx;
	logic [7:0]             slave_rx;
	logic                   slave_ss;

	// Select lines seen low since the last clear
	logic [3:0]             ss_low_seen;
	integer                 seed = 32'h4b2b;
	int                     err_value;
	int                     err_timeout;

	spi_top u_dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.req    (req),
		.rdata  (rdata),
		.rvalid (rvalid),
		.sck    (sck),
		.mosi   (mosi),
		.miso   (miso),
		.ss_n   (ss_n)
	);

	assign slave_ss = ss_n[slave_sel];

	spi_slave_model u_slave (
		.ss_n    (slave_ss),
		.sck     (sck),
		.mosi    (mosi),
		.cpol    (slave_cpol),
		.cpha    (slave_cpha),
		.order   (slave_order),
		.tx_byte (slave_tx),
		.miso    (miso),
		.rx_byte (slave_rx)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(negedge clk) begin
		ss_low_seen = ss_low_seen | ~ss_n;
	end

	function logic [7:0] next_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// CTRL bus word, bit 31 is the start command
	function automatic logic [31:0] ctrl_word(input logic start,
			input logic [23:0] prescale, input logic [1:0] sel, input logic order,
			input logic cpha, input logic cpol, input logic turnon);
		spi_ctrl_t c;
		c.prescale = prescale;
		c.select   = sel;
		c.order    = order;
		c.cpha     = cpha;
		c.cpol     = cpol;
		c.turnon   = turnon;
		return {start, 1'b0, c};
	endfunction

	task automatic cmp_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error @ %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
			err_value++;
		end
	endtask

	task automatic cmp_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("** Error @ %0t ns: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
			err_value++;
		end
	endtask

	task automatic cmp_status(input string name, input spi_status_t got,
			input spi_status_t exp);
		if (got !== exp) begin
			$display("** Error @ %0t ns: %s got done=%b busy=%b expected done=%b busy=%b",
				$time, name, got.done, got.busy, exp.done, exp.busy);
			err_value++;
		end
	endtask

	task automatic cmp_ss(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			$display("** Error @ %0t ns: %s got %b expected %b", $time, name, got, exp);
			err_value++;
		end
	endtask

	// Single pins such as sck, mosi and rvalid
	task automatic cmp_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error @ %0t ns: %s got %b expected %b", $time, name, got, exp);
			err_value++;
		end
	endtask

	task automatic end_run();
		int err_assert;
		err_assert = u_dut.u_engine.u_props.fail_cnt;
		$display("Checks finished: %0d value errors, %0d timeouts, %0d assertion failures",
			err_value, err_timeout, err_assert);
		if ((err_value == 0) && (err_timeout == 0) && (err_assert == 0)) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	// One-cycle write strobe
	task automatic bus_write(input logic [1:0] addr, input logic [31:0] data);
		@(negedge clk);
		req.wr    = 1'b1;
		req.rd    = 1'b0;
		req.addr  = addr;
		req.wdata = data;
		@(negedge clk);
		req = '0;
	endtask

	task automatic bus_read(input logic [1:0] addr, output logic [31:0] data);
		int n;
		@(negedge clk);
		req.wr    = 1'b0;
		req.rd    = 1'b1;
		req.addr  = addr;
		req.wdata = '0;
		@(negedge clk);
		req = '0;
		n = 0;
		while (!rvalid && (n < RD_LIMIT)) begin
			@(negedge clk);
			n++;
		end
		if (!rvalid) begin
			$display("Timeout: no read response for address %0d", addr);
			err_timeout++;
		end else begin
			data = rdata;
		end
	endtask

	// Wait for any select low, or for all released
	task automatic wait_select(input logic want_low, input int limit);
		int n;
		n = 0;
		while (((ss_n != 4'hF) != want_low) && (n < limit)) begin
			@(negedge clk);
			n++;
		end
		if ((ss_n != 4'hF) != want_low) begin
			$display("Timeout: slave select did not %s within %0d cycles",
				want_low ? "assert" : "release", limit);
			err_timeout++;
		end
	endtask

	task automatic poll_done(input int limit);
		logic [31:0] w;
		spi_status_t st;
		int          n;
		st = '0;
		n  = 0;
		while (!st.done && (n < limit)) begin
			bus_read(`SPI_ADDR_STATUS, w);
			st = w[1:0];
			n++;
		end
		if (!st.done) begin
			$display("Timeout: transfer not done after %0d status reads", limit);
			err_timeout++;
		end
	endtask

	// Full frame with checks on both byte directions
	task automatic run_frame(input logic [1:0] sel, input logic order, input logic cpha,
			input logic cpol, input logic [23:0] prescale, input logic [7:0] tx,
			input logic [7:0] slv);
		logic [31:0] w;
		logic [3:0]  ss_exp;
		slave_sel   = sel;
		slave_order = order;
		slave_cpha  = cpha;
		slave_cpol  = cpol;
		slave_tx    = slv;
		// Only the selected line may go low
		ss_exp      = 4'hF;
		ss_exp[sel] = 1'b0;
		// Mode change first, sck settles to the new cpol while idle
		bus_write(`SPI_ADDR_CTRL, ctrl_word(1'b0, prescale, sel, order, cpha, cpol, 1'b1));
		@(negedge clk);
		cmp_bit("sck idle", sck, cpol);
		bus_write(`SPI_ADDR_TXDATA, {24'h0, tx});
		ss_low_seen = '0;
		bus_write(`SPI_ADDR_CTRL, ctrl_word(1'b1, prescale, sel, order, cpha, cpol, 1'b1));
		poll_done(POLL_LIMIT);
		cmp_ss("ss_n during frame", ~ss_low_seen, ss_exp);
		cmp_ss("ss_n after done", ss_n, 4'hF);
		cmp_bit("mosi after done", mosi, 1'b1);
		bus_read(`SPI_ADDR_RXDATA, w);
		cmp_word("RXDATA", w, {24'h0, slv});
		cmp_byte("slave rx_byte", slave_rx, tx);
	endtask

	task automatic test_reset();
		logic [31:0] w;
		logic [31:0] r;
		logic [31:0] exp;
		cmp_bit("rvalid after reset", rvalid, 1'b0);
		cmp_ss("ss_n after reset", ss_n, 4'hF);
		cmp_bit("sck after reset", sck, 1'b0);
		cmp_bit("mosi after reset", mosi, 1'b1);
		bus_read(`SPI_ADDR_STATUS, r);
		cmp_status("STATUS after reset", r[1:0], spi_status_t'(2'b00));
		cmp_word("STATUS word after reset", r, 32'h0);
		w = $random(seed);
		bus_write(`SPI_ADDR_TXDATA, w);
		bus_read(`SPI_ADDR_TXDATA, r);
		cmp_word("TXDATA readback", r, w);
		// Start bit set but turnon clear, so nothing runs
		w = $random(seed);
		w[31] = 1'b1;
		w[0]  = 1'b0;
		bus_write(`SPI_ADDR_CTRL, w);
		bus_read(`SPI_ADDR_CTRL, r);
		exp = '0;
		exp[$bits(spi_ctrl_t)-1:0] = w[$bits(spi_ctrl_t)-1:0];
		cmp_word("CTRL readback", r, exp);
	endtask

	task automatic test_mode0();
		run_frame(2'd0, 1'b0, 1'b0, 1'b0, 24'd1, next_byte(), next_byte());
	endtask

	// Every cpol/cpha pair in both bit orders
	task automatic test_modes();
		for (int m = 0; m < 4; m++) begin
			for (int o = 0; o < 2; o++) begin
				run_frame(m[1:0], o[0], m[0], m[1], 24'(m), next_byte(), next_byte());
			end
		end
	endtask

	task automatic test_select();
		for (int s = 0; s < 4; s++) begin
			run_frame(s[1:0], 1'b0, 1'b0, 1'b0, 24'd0, next_byte(), next_byte());
		end
	endtask

	task automatic test_busy_done();
		logic [7:0]  tx1;
		logic [7:0]  tx2;
		logic [7:0]  slv1;
		logic [31:0] cw;
		logic [31:0] w;
		tx1  = next_byte();
		tx2  = ~tx1;
		slv1 = next_byte();
		slave_sel   = 2'd1;
		slave_order = 1'b0;
		slave_cpha  = 1'b1;
		slave_cpol  = 1'b0;
		slave_tx    = slv1;
		cw = ctrl_word(1'b1, 24'd2, 2'd1, 1'b0, 1'b1, 1'b0, 1'b1);
		bus_write(`SPI_ADDR_TXDATA, {24'h0, tx1});
		bus_write(`SPI_ADDR_CTRL, cw);
		wait_select(1'b1, 10);
		// Second start mid-frame with a new byte queued
		bus_write(`SPI_ADDR_TXDATA, {24'h0, tx2});
		bus_write(`SPI_ADDR_CTRL, cw);
		bus_read(`SPI_ADDR_STATUS, w);
		cmp_status("STATUS mid-frame", w[1:0], spi_status_t'{done: 1'b0, busy: 1'b1});
		wait_select(1'b0, PIN_LIMIT);
		repeat (6) @(negedge clk);
		// Sticky done until the first STATUS read
		bus_read(`SPI_ADDR_STATUS, w);
		cmp_status("STATUS after frame", w[1:0], spi_status_t'{done: 1'b1, busy: 1'b0});
		bus_read(`SPI_ADDR_STATUS, w);
		cmp_status("STATUS second read", w[1:0], spi_status_t'{done: 1'b0, busy: 1'b0});
		bus_read(`SPI_ADDR_RXDATA, w);
		cmp_word("RXDATA after ignored start", w, {24'h0, slv1});
		cmp_byte("slave rx_byte after ignored start", slave_rx, tx1);
	endtask

	task automatic test_off();
		logic [31:0] w;
		bus_write(`SPI_ADDR_CTRL, ctrl_word(1'b1, 24'd0, 2'd2, 1'b0, 1'b0, 1'b0, 1'b0));
		for (int n = 0; n < 40; n++) begin
			@(negedge clk);
			cmp_ss("ss_n while off", ss_n, 4'hF);
		end
		bus_read(`SPI_ADDR_STATUS, w);
		cmp_status("STATUS while off", w[1:0], spi_status_t'{done: 1'b0, busy: 1'b0});
	endtask

	initial begin
		rst_n       = 1'b0;
		req         = '0;
		slave_sel   = 2'd0;
		slave_cpol  = 1'b0;
		slave_cpha  = 1'b0;
		slave_order = 1'b0;
		slave_tx    = 8'h00;
		ss_low_seen = '0;
		err_value   = 0;
		err_timeout = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_reset();
		test_mode0();
		test_modes();
		test_select();
		test_busy_done();
		test_off();
		end_run();
	end

endmodule

`default_nettype wire

// File: dv/spi_properties.sv
`timescale 1ns/1ps
`default_nettype none

module spi_properties (
	input wire logic       clk,
	input wire logic       rst_n,
	input wire logic [3:0] ss_n,
	input wire logic       sck,
	input wire logic       cpol,
	input wire logic       busy,
	input wire logic       frame_done
);

	// Assertion failures so far
	int fail_cnt = 0;

	// One slave at a time
	a_one_select: assert property (@(posedge clk) disable iff (!rst_n)
		$countones(~ss_n) <= 1)
		else begin
			fail_cnt++;
			$error("more than one slave select low, ss_n=%b", ss_n);
		end

	// Idle bus parks sck at the frame polarity
	a_idle_sck: assert property (@(posedge clk) disable iff (!rst_n)
		(&ss_n) |-> (sck == cpol))
		else begin
			fail_cnt++;
			$error("sck=%b differs from cpol=%b with no slave selected", sck, cpol);
		end

	// Frame end only from an active frame
	a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
		frame_done |-> $past(busy))
		else begin
			fail_cnt++;
			$error("frame_done without busy in the previous cycle");
		end

endmodule

// Attached to every shift engine, cpol taken from the latched frame settings
bind spi_shift_engine spi_properties u_props (
	.clk        (clk),
	.rst_n      (rst_n),
	.ss_n       (ss_n),
	.sck        (sck),
	.cpol       (cfg.cpol),
	.busy       (busy),
	.frame_done (frame_done)
);

`default_nettype wire

// File: dv/spi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module spi_slave_model (
	input  wire logic                       ss_n,
	input  wire logic                       sck,
	input  wire logic                       mosi,
	input  wire logic                       cpol,
	input  wire logic                       cpha,
	input  wire logic                       order,
	input  wire logic [`SPI_FRAME_BITS-1:0] tx_byte,
	output logic                            miso,
	output logic [`SPI_FRAME_BITS-1:0]      rx_byte
);

	// Bits handled so far in this frame
	int k;

	// Bit position of the n-th bit on the wire
	function automatic int pos(input logic lsb_first, input int n);
		return lsb_first ? n : `SPI_FRAME_BITS - 1 - n;
	endfunction

	initial begin
		miso    = 1'b1;
		rx_byte = '0;
		k       = 0;
	end

	// First bit on miso before any sck edge
	always @(negedge ss_n) begin
		k    = 0;
		miso = tx_byte[pos(order, 0)];
	end

	always @(sck) begin
		if (!ss_n && (k < `SPI_FRAME_BITS)) begin
			// Leading edge leaves the idle level
			if ((sck != cpol) ^ cpha) begin
				// Sample edge
				rx_byte[pos(order, k)] = mosi;
				if (cpha) begin
					k = k + 1;
				end
			end else begin
				// Shift edge, cpha 0 moves on to the next bit here
				if (!cpha) begin
					k = k + 1;
				end
				if (k < `SPI_FRAME_BITS) begin
					miso = tx_byte[pos(order, k)];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/spi_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module spi_top (
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire spi_pkg::spi_bus_req_t req,
	output logic [`SPI_DATA_W-1:0]     rdata,
	output logic                       rvalid,
	output logic                       sck,
	output logic                       mosi,
	input  wire logic                  miso,
	output logic [3:0]                 ss_n
);

	import spi_pkg::*;

	// Register file to engine
	logic                       start;
	spi_ctrl_t                  ctrl;
	logic [`SPI_FRAME_BITS-1:0] tx_byte;
	logic                       busy;
	logic                       frame_done;
	logic [`SPI_FRAME_BITS-1:0] rx_byte;

	// Engine to clock generator
	logic                       run;
	logic                       tick;

	spi_regs u_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.rdata      (rdata),
		.rvalid     (rvalid),
		.busy       (busy),
		.frame_done (frame_done),
		.rx_byte    (rx_byte),
		.start      (start),
		.ctrl       (ctrl),
		.tx_byte    (tx_byte)
	);

	// Half-period enables
	spi_sck_gen u_sck_gen (
		.clk      (clk),
		.rst_n    (rst_n),
		.run      (run),
		.prescale (ctrl.prescale),
		.tick     (tick)
	);

	spi_shift_engine u_engine (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.ctrl       (ctrl),
		.tx_byte    (tx_byte),
		.tick       (tick),
		.miso       (miso),
		.run        (run),
		.busy       (busy),
		.frame_done (frame_done),
		.rx_byte    (rx_byte),
		.sck        (sck),
		.mosi       (mosi),
		.ss_n       (ss_n)
	);

endmodule

`default_nettype wire

// File: hw/spi_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module spi_regs (
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire spi_pkg::spi_bus_req_t      req,
	output logic [`SPI_DATA_W-1:0]          rdata,
	output logic                            rvalid,
	input  wire logic                       busy,
	input  wire logic                       frame_done,
	input  wire logic [`SPI_FRAME_BITS-1:0] rx_byte,
	output logic                            start,
	output spi_pkg::spi_ctrl_t              ctrl,
	output logic [`SPI_FRAME_BITS-1:0]      tx_byte
);

	import spi_pkg::*;

	logic [`SPI_DATA_W-1:0]     txdata_q;
	spi_ctrl_t                  ctrl_q;
	logic [`SPI_FRAME_BITS-1:0] rx_q;
	logic                       done_q;
	logic                       start_q;

	logic                       wr_ctrl;
	spi_ctrl_t                  wr_ctrl_val;
	logic                       rd_status;
	spi_status_t                status;
	logic [`SPI_DATA_W-1:0]     rd_mux;

	assign wr_ctrl     = req.wr && (req.addr == `SPI_ADDR_CTRL);
	// Bits 30 and 31 are not stored
	assign wr_ctrl_val = req.wdata[$bits(spi_ctrl_t)-1:0];
	assign rd_status   = req.rd && (req.addr == `SPI_ADDR_STATUS);

	assign status.done = done_q;
	assign status.busy = busy;

	always_ff @(posedge clk) begin
		if (req.wr && (req.addr == `SPI_ADDR_TXDATA)) begin
			txdata_q <= req.wdata;
		end
		// Last received byte
		if (frame_done) begin
			rx_q <= rx_byte;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctrl_q  <= '0;
			start_q <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			if (wr_ctrl) begin
				ctrl_q <= wr_ctrl_val;
			end
			// Start pulse one cycle after the write, engine sees the new ctrl
			// Turnon comes from the same write, back-to-back starts are dropped
			start_q <= wr_ctrl && req.wdata[`SPI_CTRL_START_BIT] && wr_ctrl_val.turnon &&
			           !busy && !start_q;
			// Sticky done, a finishing frame wins over a clearing read
			if (frame_done) begin
				done_q <= 1'b1;
			end else if (rd_status) begin
				done_q <= 1'b0;
			end
		end
	end

	// Read mux, narrow registers zero-extended
	always_comb begin
		rd_mux = '0;
		case (req.addr)
			`SPI_ADDR_TXDATA: rd_mux = txdata_q;
			`SPI_ADDR_CTRL:   rd_mux[$bits(spi_ctrl_t)-1:0] = ctrl_q;
			`SPI_ADDR_RXDATA: rd_mux[`SPI_FRAME_BITS-1:0] = rx_q;
			`SPI_ADDR_STATUS: rd_mux[$bits(spi_status_t)-1:0] = status;
			default:          rd_mux = '0;
		endcase
	end

	// Read data one cycle after the strobe
	always_ff @(posedge clk) begin
		if (req.rd) begin
			rdata <= rd_mux;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
		end else begin
			rvalid <= req.rd;
		end
	end

	assign start   = start_q;
	assign ctrl    = ctrl_q;
	assign tx_byte = txdata_q[`SPI_FRAME_BITS-1:0];

endmodule

`default_nettype wire

// File: hw/spi_shift_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module spi_shift_engine (
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire logic                       start,
	input  wire spi_pkg::spi_ctrl_t         ctrl,
	input  wire logic [`SPI_FRAME_BITS-1:0] tx_byte,
	input  wire logic                       tick,
	input  wire logic                       miso,
	output logic                            run,
	output logic                            busy,
	output logic                            frame_done,
	output logic [`SPI_FRAME_BITS-1:0]      rx_byte,
	output logic                            sck,
	output logic                            mosi,
	output logic [3:0]                      ss_n
);

	import spi_pkg::*;

	spi_state_e                 state;
	// Frame settings, tracks ctrl while idle and freezes for a frame
	spi_ctrl_t                  cfg;
	// SHIFT half-period index
	logic [3:0]                 half_cnt;
	logic [`SPI_FRAME_BITS-1:0] tx_q;
	logic [`SPI_FRAME_BITS-1:0] rx_q;
	logic                       sck_q;
	logic                       mosi_q;
	logic [3:0]                 ss_q;

	logic                       launch;
	logic                       edge_en;
	logic [3:0]                 edge_idx;
	logic                       leading;
	logic [2:0]                 edge_bit;
	logic                       sample_now;
	logic                       drive_now;
	logic [2:0]                 drive_bit;

	// Bit position for the k-th bit of a frame
	function automatic logic [2:0] bit_idx(input logic lsb_first, input logic [2:0] k);
		return lsb_first ? k : 3'd7 - k;
	endfunction

	assign launch = (state == IDLE) && start && ctrl.turnon;

	// Sixteen sck edges, edge 0 ends SETUP, edges 1..15 end SHIFT halves 0..14
	// The last SHIFT half has no edge, sck is already back at cpol
	assign edge_en  = ctrl.turnon && tick &&
	                  ((state == SETUP) || ((state == SHIFT) && (half_cnt != 4'd15)));
	assign edge_idx = (state == SETUP) ? 4'd0 : half_cnt + 4'd1;
	// Even edges leave the idle level
	assign leading  = ~edge_idx[0];
	assign edge_bit = edge_idx[3:1];

	// cpha 0 samples on leading edges, cpha 1 on trailing edges
	assign sample_now = edge_en && (leading ^ cfg.cpha);
	// The other edge moves mosi, cpha 0 has bit 0 out before the first edge
	assign drive_now  = edge_en && !(leading ^ cfg.cpha) && (cfg.cpha || (edge_bit != 3'd7));
	assign drive_bit  = cfg.cpha ? edge_bit : edge_bit + 3'd1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= IDLE;
			cfg      <= '0;
			half_cnt <= '0;
			sck_q    <= 1'b0;
			mosi_q   <= 1'b1;
			ss_q     <= 4'hF;
		end else if (!ctrl.turnon) begin
			// Disabled, drop any frame and park the pins
			state    <= IDLE;
			cfg      <= ctrl;
			half_cnt <= '0;
			sck_q    <= ctrl.cpol;
			mosi_q   <= 1'b1;
			ss_q     <= 4'hF;
		end else begin
			if (edge_en) begin
				sck_q <= ~sck_q;
			end
			if (drive_now) begin
				mosi_q <= tx_q[bit_idx(cfg.order, drive_bit)];
			end
			case (state)
				IDLE: begin
					// sck follows cpol between frames
					cfg   <= ctrl;
					sck_q <= ctrl.cpol;
					if (launch) begin
						half_cnt <= '0;
						ss_q     <= ~(4'b0001 << ctrl.select);
						// First bit out during SETUP
						mosi_q   <= ctrl.order ? tx_byte[0] : tx_byte[7];
						state    <= SETUP;
					end
				end
				SETUP: begin
					if (tick) begin
						state <= SHIFT;
					end
				end
				SHIFT: begin
					if (tick) begin
						if (half_cnt == 4'd15) begin
							state <= FINISH;
						end else begin
							half_cnt <= half_cnt + 4'd1;
						end
					end
				end
				FINISH: begin
					// End of frame, release the slave
					if (tick) begin
						sck_q  <= cfg.cpol;
						mosi_q <= 1'b1;
						ss_q   <= 4'hF;
						state  <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Shift data
	always_ff @(posedge clk) begin
		if (launch) begin
			tx_q <= tx_byte;
		end
		if (sample_now) begin
			rx_q[bit_idx(cfg.order, edge_bit)] <= miso;
		end
	end

	assign run        = (state != IDLE);
	assign busy       = (state != IDLE);
	// Same edge that returns the engine to IDLE
	assign frame_done = ctrl.turnon && tick && (state == FINISH);
	assign rx_byte    = rx_q;
	assign sck        = sck_q;
	assign mosi       = mosi_q;
	assign ss_n       = ss_q;

endmodule

`default_nettype wire

// File: hw/spi_sck_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module spi_sck_gen (
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire logic                       run,
	input  wire logic [`SPI_PRESCALE_W-1:0] prescale,
	output logic                            tick
);

	// Cycles elapsed in the current half-period
	logic [`SPI_PRESCALE_W-1:0] cnt;
	logic                       at_end;

	// Last cycle of a half-period
	// Compare with >= so a smaller prescale written mid-count still wraps
	assign at_end = (cnt >= prescale);

	// One enable cycle per prescale+1 clocks
	assign tick = run && at_end;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (!run) begin
			// Held at zero so the first half-period after start is full length
			cnt <= '0;
		end else if (at_end) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hw/spi_pkg.sv
`default_nettype none

`include "spi_defines.svh"

package spi_pkg;

	// CTRL register contents, bit 31 of the bus word is the start command
	// Field order from msb: prescale, select, order, cpha, cpol, turnon
	typedef struct packed {
		logic [`SPI_PRESCALE_W-1:0] prescale;
		// Slave number, drives one of four ss_n lines
		logic [1:0]                 select;
		// 1 means LSB first
		logic                       order;
		logic                       cpha;
		logic                       cpol;
		// Peripheral enable
		logic                       turnon;
	} spi_ctrl_t;

	// STATUS register, done in bit 1, busy in bit 0
	typedef struct packed {
		logic done;
		logic busy;
	} spi_status_t;

	// Host strobe bus request
	typedef struct packed {
		logic                   wr;
		logic                   rd;
		logic [1:0]             addr;
		logic [`SPI_DATA_W-1:0] wdata;
	} spi_bus_req_t;

	// Shift engine states
	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		SHIFT,
		FINISH
	} spi_state_e;

endpackage

`default_nettype wire

// File: hw/spi_defines.svh
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// Register word addresses on the host bus
`define SPI_ADDR_TXDATA 2'd0
`define SPI_ADDR_CTRL   2'd1
`define SPI_ADDR_RXDATA 2'd2
`define SPI_ADDR_STATUS 2'd3

// Host bus data width
`define SPI_DATA_W 32

// Serial clock prescaler width
`define SPI_PRESCALE_W 24

// Bits per serial frame
`define SPI_FRAME_BITS 8

// Start command bit inside a CTRL write
`define SPI_CTRL_START_BIT 31

`endif
